/* board_power.f */
+incdir+verilog
verilog/board_power_pkg.sv
verilog/rail_sequencer.sv
verilog/pgood_monitor.sv
verilog/board_power_top.sv
verif/board_power_chk.sv
verif/board_power_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f board_power.f --top-module board_power_tb -o board_power_sim \
  && ./obj_dir/board_power_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
[ -f sim.log ] && cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
[ "$sim_status" -eq 0 ] || { echo "Build or simulation error"; exit 1; }
echo "Simulation passed"

/* verif/board_power_tb.sv */
`include "board_power_defs.svh"

module board_power_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int UP_CYCLES     = `PWR_T0 + `PWR_T1 + 3;
  localparam int SEL_UP_DONE   = 0;
  localparam int SEL_DOWN_DONE = 1;
  localparam int SEL_FAULT     = 2;
  localparam int SEL_GROUP     = 3;     // Plus group index
  localparam int PULSE_UP      = 0;
  localparam int PULSE_DOWN    = 1;
  localparam int PULSE_CLEAR   = 2;

  logic                         clk;
  logic                         reset;
  logic                         power_up;
  logic                         power_down;
  logic                         fault_clear;
  logic                         power_up_done;
  logic                         power_down_done;
  logic                         fault;
  board_power_pkg::rail_group_t fault_groups;
  board_power_pkg::rail_group_t pgood;
  logic                         atx_ps_on_n;
  logic                         g12v_en;
  logic                         g5v_en;
  logic                         g3v3_en;
  logic                         track_2v5;
  logic                         inhibit_2v5;
  logic                         inhibit_1v8;
  logic                         inhibit_1v5;
  logic                         inhibit_1v2;
  logic                         inhibit_1v0;
  logic                         mgt_avcc_en;
  logic                         mgt_avttx_en;
  logic                         mgt_avccpll_en;

  board_power_pkg::rail_group_t pins_on;
  board_power_pkg::rail_group_t drop_mask;  // Held-low power-good bits
  int                           on_cnt [3];
  int                           errors;
  logic [31:0]                  rng;

  board_power_top u_dut (.*);

  bind board_power_top board_power_chk u_chk (.*);

  always #4 clk = ~clk;

  // ========================================
  // Rail model
  // ========================================

  assign pins_on[0] = !atx_ps_on_n && g12v_en && g5v_en && g3v3_en;
  assign pins_on[1] = track_2v5 && !inhibit_2v5 && !inhibit_1v8 && !inhibit_1v5 &&
                      !inhibit_1v2 && !inhibit_1v0;
  assign pins_on[2] = mgt_avcc_en && mgt_avttx_en && mgt_avccpll_en;

  always @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (!pins_on[i]) begin
        on_cnt[i] <= 0;
        pgood[i]  <= 1'b0;
      end else begin
        if (on_cnt[i] < 3) begin
          on_cnt[i] <= on_cnt[i] + 1;
        end
        pgood[i] <= (on_cnt[i] >= 2) && !drop_mask[i];  // Good 3 cycles after enable
      end
    end
  end

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rng = xorshift32(rng);
    return int'(rng % 32'(n));
  endfunction

  function automatic logic status_bit(input int sel);
    case (sel)
      SEL_UP_DONE:   return power_up_done;
      SEL_DOWN_DONE: return power_down_done;
      SEL_FAULT:     return fault;
      default:       return pins_on[sel - SEL_GROUP];
    endcase
  endfunction

  task automatic skip_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic send_pulse(input int which);
    case (which)
      PULSE_UP:   power_up <= 1'b1;
      PULSE_DOWN: power_down <= 1'b1;
      default:    fault_clear <= 1'b1;
    endcase
    @(posedge clk);
    power_up    <= 1'b0;
    power_down  <= 1'b0;
    fault_clear <= 1'b0;
  endtask

  task automatic wait_until(input int sel, input int limit, input string what);
    int n;
    n = 0;
    @(posedge clk);
    while (!status_bit(sel) && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!status_bit(sel)) begin
      $display("Timeout after %0d cycles waiting for %s", limit, what);
      errors++;
    end
  endtask

  // Host keeps pulsing clear while the rails are still up
  task automatic catch_fault(input int limit);
    int n;
    n = 0;
    fault_clear <= 1'b1;
    @(posedge clk);
    while (!status_bit(SEL_FAULT) && n < limit) begin
      @(posedge clk);
      n++;
    end
    fault_clear <= 1'b0;
    if (!status_bit(SEL_FAULT)) begin
      $display("Timeout after %0d cycles waiting for the fault to latch", limit);
      errors++;
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================

  initial begin
    int fault_grp;
    clk         = 1'b0;
    reset       = 1'b1;
    power_up    = 1'b0;
    power_down  = 1'b0;
    fault_clear = 1'b0;
    pgood       = '0;
    drop_mask   = '0;
    errors      = 0;
    rng         = 32'hd1b8;

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait_until(SEL_DOWN_DONE, 4, "power_down_done after reset");
    compare_value("fault", fault, 0);
    compare_value("fault_groups", fault_groups, 0);

    // Full sequence, then a repeated request while up
    send_pulse(PULSE_UP);
    wait_until(SEL_UP_DONE, UP_CYCLES + 5, "power_up_done");
    skip_cycles(10);
    send_pulse(PULSE_UP);
    skip_cycles(3);
    compare_value("power_up_done", power_up_done, 1);
    send_pulse(PULSE_DOWN);
    wait_until(SEL_DOWN_DONE, 4, "power_down_done");
    send_pulse(PULSE_DOWN);

    // Aborts at random points
    for (int k = 0; k < 8; k++) begin
      send_pulse(PULSE_UP);
      skip_cycles(rand_below(UP_CYCLES + 4));
      send_pulse(PULSE_DOWN);
      wait_until(SEL_DOWN_DONE, 4, "power_down_done after abort");
      skip_cycles(2);
    end

    // Power-good drops on random groups
    for (int k = 0; k < 6; k++) begin
      fault_grp = rand_below(3);
      send_pulse(PULSE_UP);
      wait_until(SEL_GROUP + fault_grp, UP_CYCLES + 5, "rail group enable");
      skip_cycles(rand_below(16));
      drop_mask[fault_grp] <= 1'b1;
      catch_fault(`PWR_GRACE + 10);
      compare_value("fault_groups", fault_groups, 32'(1) << fault_grp);
      wait_until(SEL_DOWN_DONE, 4, "power_down_done after fault");
      send_pulse(PULSE_UP);             // Locked out
      skip_cycles(3);
      compare_value("power_down_done", power_down_done, 1);
      drop_mask <= '0;
      send_pulse(PULSE_CLEAR);
      skip_cycles(1);
      compare_value("fault", fault, 0);
      compare_value("fault_groups", fault_groups, 0);
    end

    skip_cycles(5);
    $display("Error count: %0d testbench, %0d assertion", errors, u_dut.u_chk.assert_fails);
    if (errors == 0 && u_dut.u_chk.assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verif/board_power_chk.sv */
`include "board_power_defs.svh"

module board_power_chk (
  input logic                         clk,
  input logic                         reset,
  input logic                         power_up,
  input logic                         power_down,
  input logic                         fault_clear,
  input logic                         power_up_done,
  input logic                         power_down_done,
  input logic                         fault,
  input board_power_pkg::rail_group_t fault_groups,
  input board_power_pkg::rail_group_t pgood,
  input logic                         atx_ps_on_n,
  input logic                         g12v_en,
  input logic                         g5v_en,
  input logic                         g3v3_en,
  input logic                         track_2v5,
  input logic                         inhibit_2v5,
  input logic                         inhibit_1v8,
  input logic                         inhibit_1v5,
  input logic                         inhibit_1v2,
  input logic                         inhibit_1v0,
  input logic                         mgt_avcc_en,
  input logic                         mgt_avttx_en,
  input logic                         mgt_avccpll_en
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int UP_CYCLES = `PWR_T0 + `PWR_T1 + 3;
  localparam int GRACE     = `PWR_GRACE;

  int unsigned                  assert_fails = 0;
  int                           up_left;
  int                           age [3];
  board_power_pkg::rail_group_t en;
  board_power_pkg::rail_group_t fail_now;
  logic                         any_inhibit;
  logic                         all_inhibit;
  logic                         rails_off;

  assign any_inhibit = inhibit_2v5 || inhibit_1v8 || inhibit_1v5 || inhibit_1v2 ||
                       inhibit_1v0;
  assign all_inhibit = inhibit_2v5 && inhibit_1v8 && inhibit_1v5 && inhibit_1v2 &&
                       inhibit_1v0;

  // Group state as seen on the board pins
  assign en[0] = !atx_ps_on_n && g12v_en && g5v_en && g3v3_en;
  assign en[1] = track_2v5 && !any_inhibit;
  assign en[2] = mgt_avcc_en && mgt_avttx_en && mgt_avccpll_en;

  assign rails_off = atx_ps_on_n && !g12v_en && !g5v_en && !g3v3_en && !track_2v5 &&
                     all_inhibit && !mgt_avcc_en && !mgt_avttx_en && !mgt_avccpll_en;

  // ========================================
  // Expected timing
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      up_left <= 0;
    end else if (power_up && !power_down && power_down_done && !fault) begin
      up_left <= UP_CYCLES;             // Cycles until power_up_done
    end else if (power_down || fault) begin
      up_left <= 0;
    end else if (up_left != 0) begin
      up_left <= up_left - 1;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (reset || !en[i]) begin
        age[i] <= 0;
      end else if (age[i] != GRACE) begin
        age[i] <= age[i] + 1;           // Saturates at grace time
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      fail_now[i] = en[i] && (age[i] == GRACE) && !pgood[i];
    end
  end

  // ========================================
  // Assertions
  // ========================================

  a_off_levels: assert property (@(posedge clk) power_down_done |-> rails_off)
    else begin
      $error("Rails not at off levels while powered down");
      assert_fails++;
    end

  a_up_not_early: assert property (@(posedge clk) disable iff (reset)
    up_left > 1 |-> !power_up_done)
    else begin
      $error("power_up_done high before the sequence time");
      assert_fails++;
    end

  a_up_on_time: assert property (@(posedge clk) disable iff (reset)
    up_left == 1 |-> power_up_done)
    else begin
      $error("power_up_done missing at the end of the sequence");
      assert_fails++;
    end

  a_mgt_order: assert property (@(posedge clk)
    (mgt_avcc_en || mgt_avttx_en || mgt_avccpll_en) |-> !any_inhibit)
    else begin
      $error("Transceiver rail enabled while an inhibit is high");
      assert_fails++;
    end

  a_inhibit_order: assert property (@(posedge clk) !g3v3_en |-> all_inhibit)
    else begin
      $error("Inhibit released while 3.3 V is off");
      assert_fails++;
    end

  a_down_abort: assert property (@(posedge clk) disable iff (reset)
    power_down |=> power_down_done && rails_off)
    else begin
      $error("Down request did not turn the rails off");
      assert_fails++;
    end

  a_fault_latch: assert property (@(posedge clk) disable iff (reset)
    |fail_now |=> fault && ((fault_groups & $past(fail_now)) == $past(fail_now)))
    else begin
      $error("Missing power-good did not latch the fault");
      assert_fails++;
    end

  a_fault_rails_off: assert property (@(posedge clk) disable iff (reset)
    (|fail_now) && !fault |-> ##2 (power_down_done && rails_off))
    else begin
      $error("Rails still on two cycles after a power-good drop");
      assert_fails++;
    end

  a_up_lockout: assert property (@(posedge clk) disable iff (reset)
    fault && power_up && power_down_done |=> power_down_done)
    else begin
      $error("Power-up accepted while a fault is latched");
      assert_fails++;
    end

  a_clear_down: assert property (@(posedge clk) disable iff (reset)
    fault_clear && power_down_done |=> !fault && (fault_groups == '0))
    else begin
      $error("Fault clear while powered down did not clear the fault");
      assert_fails++;
    end

  a_clear_ignored: assert property (@(posedge clk) disable iff (reset)
    fault && fault_clear && !power_down_done |=> fault)
    else begin
      $error("Fault cleared while the rails were still on");
      assert_fails++;
    end

endmodule

/* verilog/board_power_top.sv */
module board_power_top (
  input  logic                         clk,
  input  logic                         reset,

  // Host strobes and status
  input  logic                         power_up,
  input  logic                         power_down,
  input  logic                         fault_clear,
  output logic                         power_up_done,
  output logic                         power_down_done,
  output logic                         fault,
  output board_power_pkg::rail_group_t fault_groups,

  // Board supplies
  output logic                         atx_ps_on_n,
  output logic                         g12v_en,
  output logic                         g5v_en,
  output logic                         g3v3_en,
  output logic                         track_2v5,
  output logic                         inhibit_2v5,
  output logic                         inhibit_1v8,
  output logic                         inhibit_1v5,
  output logic                         inhibit_1v2,
  output logic                         inhibit_1v0,
  output logic                         mgt_avcc_en,
  output logic                         mgt_avttx_en,
  output logic                         mgt_avccpll_en,
  input  board_power_pkg::rail_group_t pgood
);

  logic                         seq_up;
  logic                         seq_down;
  board_power_pkg::rail_group_t group_en;

  // ========================================
  // Power-good monitor
  // ========================================

  pgood_monitor u_monitor (
    .clk          (clk),
    .reset        (reset),
    .power_up     (power_up),
    .power_down   (power_down),
    .fault_clear  (fault_clear),
    .powered_down (power_down_done),    // Same level as the host status
    .group_en     (group_en),
    .pgood        (pgood),
    .seq_up       (seq_up),
    .seq_down     (seq_down),
    .fault        (fault),
    .fault_groups (fault_groups)
  );

  // ========================================
  // Rail sequencer
  // ========================================

  rail_sequencer u_sequencer (
    .clk             (clk),
    .reset           (reset),
    .seq_up          (seq_up),
    .seq_down        (seq_down),
    .power_up_done   (power_up_done),
    .power_down_done (power_down_done),
    .group_en        (group_en),
    .atx_ps_on_n     (atx_ps_on_n),
    .g12v_en         (g12v_en),
    .g5v_en          (g5v_en),
    .g3v3_en         (g3v3_en),
    .track_2v5       (track_2v5),
    .inhibit_2v5     (inhibit_2v5),
    .inhibit_1v8     (inhibit_1v8),
    .inhibit_1v5     (inhibit_1v5),
    .inhibit_1v2     (inhibit_1v2),
    .inhibit_1v0     (inhibit_1v0),
    .mgt_avcc_en     (mgt_avcc_en),
    .mgt_avttx_en    (mgt_avttx_en),
    .mgt_avccpll_en  (mgt_avccpll_en)
  );

endmodule

/* verilog/pgood_monitor.sv */
`include "board_power_defs.svh"

module pgood_monitor (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         power_up,
  input  logic                         power_down,
  input  logic                         fault_clear,
  input  logic                         powered_down,
  input  board_power_pkg::rail_group_t group_en,
  input  board_power_pkg::rail_group_t pgood,
  output logic                         seq_up,
  output logic                         seq_down,
  output logic                         fault,
  output board_power_pkg::rail_group_t fault_groups
);

  localparam board_power_pkg::pwr_timer_t GRACE_TIME =
    board_power_pkg::pwr_timer_t'(`PWR_GRACE);

  board_power_pkg::pwr_timer_t  grace_cnt [3];
  board_power_pkg::rail_group_t grace_done;
  board_power_pkg::rail_group_t fail;
  logic                         fault_entry;
  logic                         down_pulse;

  // ========================================
  // Grace timers
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 3; i++) begin
        grace_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (!group_en[i]) begin
          grace_cnt[i] <= '0;           // Restart on every enable
        end else if (!grace_done[i]) begin
          grace_cnt[i] <= grace_cnt[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      grace_done[i] = (grace_cnt[i] == GRACE_TIME);
    end
  end

  // Enabled, past grace, good bit missing
  assign fail        = group_en & grace_done & ~pgood;
  assign fault_entry = (|fail) && !fault;

  // ========================================
  // Fault latch
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      fault        <= 1'b0;
      fault_groups <= '0;
      down_pulse   <= 1'b0;
    end else begin
      down_pulse <= fault_entry;        // One cycle, on first latch only
      if (fault_clear && powered_down) begin
        fault        <= 1'b0;
        fault_groups <= '0;
      end else if (|fail) begin
        fault        <= 1'b1;
        fault_groups <= fault_groups | fail;  // Sticky per group
      end
    end
  end

  // ========================================
  // Sequencer commands
  // ========================================

  assign seq_up   = power_up && !fault;  // Locked out while faulted
  assign seq_down = power_down || down_pulse;

endmodule

/* verilog/rail_sequencer.sv */
`include "board_power_defs.svh"

module rail_sequencer (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         seq_up,
  input  logic                         seq_down,
  output logic                         power_up_done,
  output logic                         power_down_done,
  output board_power_pkg::rail_group_t group_en,
  output logic                         atx_ps_on_n,
  output logic                         g12v_en,
  output logic                         g5v_en,
  output logic                         g3v3_en,
  output logic                         track_2v5,
  output logic                         inhibit_2v5,
  output logic                         inhibit_1v8,
  output logic                         inhibit_1v5,
  output logic                         inhibit_1v2,
  output logic                         inhibit_1v0,
  output logic                         mgt_avcc_en,
  output logic                         mgt_avttx_en,
  output logic                         mgt_avccpll_en
);

  localparam board_power_pkg::pwr_timer_t STAGE0_TIME =
    board_power_pkg::pwr_timer_t'(`PWR_T0);
  localparam board_power_pkg::pwr_timer_t STAGE1_TIME =
    board_power_pkg::pwr_timer_t'(`PWR_T1);

  board_power_pkg::pwr_state_t  state;
  board_power_pkg::pwr_timer_t  timer;
  board_power_pkg::rail_group_t stage_en;
  logic                         timer_zero;
  logic                         bulk_on;
  logic                         pol_on;
  logic                         mgt_on;

  assign timer_zero = (timer == '0);

  // ========================================
  // Power state machine
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= board_power_pkg::PWR_DOWN;
      timer <= '0;
    end else begin
      unique case (state)
        board_power_pkg::PWR_DOWN: begin
          if (seq_up && !seq_down) begin
            state <= board_power_pkg::PWR_UPSEQ_0;
            timer <= STAGE0_TIME;
          end
        end
        board_power_pkg::PWR_UPSEQ_0: begin
          if (timer_zero) begin
            state <= board_power_pkg::PWR_UPSEQ_1;
            timer <= STAGE1_TIME;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        board_power_pkg::PWR_UPSEQ_1: begin
          if (timer_zero) begin
            state <= board_power_pkg::PWR_UP;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        board_power_pkg::PWR_UP: begin
          state <= board_power_pkg::PWR_UP;  // Hold until a down request
        end
        default: begin
          state <= board_power_pkg::PWR_DOWN;
        end
      endcase

      // Down request wins over any timer expiry
      if (seq_down) begin
        state <= board_power_pkg::PWR_DOWN;
      end
    end
  end

  // ========================================
  // Stage decode
  // ========================================

  always_comb begin
    unique case (state)
      board_power_pkg::PWR_UPSEQ_0: stage_en = 3'b001;
      board_power_pkg::PWR_UPSEQ_1: stage_en = 3'b011;
      board_power_pkg::PWR_UP:      stage_en = 3'b111;
      default:                      stage_en = 3'b000;
    endcase
  end

  // Off levels are forced while reset is held
  assign group_en = reset ? 3'b000 : stage_en;

  assign power_up_done   = !reset && (state == board_power_pkg::PWR_UP);
  assign power_down_done = reset || (state == board_power_pkg::PWR_DOWN);

  assign bulk_on = group_en[0];
  assign pol_on  = group_en[1];
  assign mgt_on  = group_en[2];

  // Bulk supplies
  assign atx_ps_on_n = !bulk_on;        // ATX PS_ON is active low
  assign g12v_en     = bulk_on;
  assign g5v_en      = bulk_on;
  assign g3v3_en     = bulk_on;

  // Point-of-load regulators
  assign track_2v5   = pol_on;
  assign inhibit_2v5 = !pol_on;
  assign inhibit_1v8 = !pol_on;
  assign inhibit_1v5 = !pol_on;
  assign inhibit_1v2 = !pol_on;
  assign inhibit_1v0 = !pol_on;

  // Transceiver analog rails
  assign mgt_avcc_en    = mgt_on;
  assign mgt_avttx_en   = mgt_on;
  assign mgt_avccpll_en = mgt_on;

endmodule

/* verilog/board_power_pkg.sv */
`include "board_power_defs.svh"

package board_power_pkg;

  // ========================================
  // Sequencer state
  // ========================================

  typedef enum logic [1:0] {
    PWR_DOWN    = 2'd0,                 // All rails off
    PWR_UPSEQ_0 = 2'd1,                 // Bulk rails on
    PWR_UPSEQ_1 = 2'd2,                 // POL regulators released
    PWR_UP      = 2'd3                  // Transceiver rails on
  } pwr_state_t;

  // ========================================
  // Vectors
  // ========================================

  // Bit 0 bulk, bit 1 point-of-load, bit 2 transceiver
  typedef logic [2:0] rail_group_t;

  typedef logic [`PWR_TIMER_W-1:0] pwr_timer_t;  // Stage and grace timers

endpackage

/* verilog/board_power_defs.svh */
`ifndef BOARD_POWER_DEFS_SVH
`define BOARD_POWER_DEFS_SVH

// ========================================
// Sequencer stage times in clock cycles
// ========================================

`define PWR_T0 10                       // Stage 0 reload, bulk rails settle
`define PWR_T1 100                      // Stage 1 reload, POL regulators settle

// ========================================
// Power-good monitor
// ========================================

`define PWR_GRACE 20                    // Cycles after enable before pgood counts

// Sized for the largest of the three values above
`define PWR_TIMER_W 8

`endif
